// File: tb.f
+incdir+common
common/exu_pkg.sv
common/exu_cmd_if.sv
common/exu_res_if.sv
hw/exu/exu_lane_alu.sv
hw/exu/exu_regfile.sv
hw/exu/exu_queue.sv
hw/exu/exu_execute.sv
hw/exu/exu_commit.sv
hw/exu_top.sv
bench/exu_assert.sv
bench/tb_exu.sv

// File: Bender.yml
package:
  name: exu

sources:
  - include_dirs:
      - common
    files:
      - common/exu_pkg.sv
      - common/exu_cmd_if.sv
      - common/exu_res_if.sv
      - hw/exu/exu_lane_alu.sv
      - hw/exu/exu_regfile.sv
      - hw/exu/exu_queue.sv
      - hw/exu/exu_execute.sv
      - hw/exu/exu_commit.sv
      - hw/exu_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/exu_assert.sv
      - bench/tb_exu.sv

// File: bench/tb_exu.sv
// ----------------------------
// EXU testbench
// ROM fetcher, reference model and in-order retire checker
// ----------------------------
`timescale 1ns/10ps
`default_nettype none
`include "exu_cfg.svh"

module tb_exu import exu_pkg::*; ();

    localparam int    N_REC  = 40;                  // Expected retire records
    localparam time   PERIOD = 100ns;

    logic      clk;
    logic      rst_n;
    logic      cmd_valid;
    logic      cmd_ready;
    logic      retire_valid;
    logic      retire_ready;
    logic      wb_en;
    logic      new_pc_req;
    exu_cmd_t  cmd;
    pc_t       retire_pc;
    pc_t       new_pc;
    pc_t       fetch_pc;                            // Next command to fetch
    pc_t       ref_pc;                              // Model PC of next retire
    exc_code_e retire_exc_code;
    xword_t    retire_trap_val;
    reg_addr_t wb_addr;
    vec_t      wb_data;
    vec_t      ref_regs [16];                       // Architectural registers
    exu_cmd_t  rom [256];                           // Indexed by PC[9:2]
    logic [31:0] lfsr = 32'hfb6b_3130;
    int        n_ret = 0;
    int        n_wait;

    exu_top exu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // ----------------------------
    // Helpers
    // ----------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);    // Galois taps
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic mismatch(input string what, input logic [127:0] got, input logic [127:0] exp);
        fail_now($sformatf("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp));
    endtask

    task automatic compare_vec(input string what, input vec_t got, input vec_t exp);
        if (got !== exp) mismatch(what, got, exp);
    endtask

    task automatic compare_pc(input string what, input pc_t got, input pc_t exp);
        if (got !== exp) mismatch(what, got, exp);
    endtask

    task automatic compare_exc(input string what, input exc_code_e got, input exc_code_e exp);
        if (got !== exp) mismatch(what, got, exp);
    endtask

    task automatic compare_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) mismatch(what, got, exp);
    endtask

    task automatic compare_bit(input string what, input logic got, input logic exp);
        if (got !== exp) mismatch(what, got, exp);
    endtask

    function automatic exu_cmd_t make_cmd(input reg_addr_t rd, input reg_addr_t rs1,
            input reg_addr_t rs2, input xword_t imm, input alu_cmd_e alu,
            input op2_sel_e sel, input wb_sel_e wb);
        exu_cmd_t c;
        c          = '0;
        c.rd       = rd;
        c.rs1      = rs1;
        c.rs2      = rs2;
        c.imm      = imm;
        c.alu_cmd  = alu;
        c.op2_sel  = sel;
        c.sum2_sel = SUM2_PC_IMM;
        c.wb_sel   = wb;
        return c;
    endfunction

    // ----------------------------
    // Reference model
    // ----------------------------
    function automatic xword_t lane_op(input alu_cmd_e op, input xword_t a, input xword_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT, ALU_LT: return ($signed(a) < $signed(b)) ? 1 : 0;
            ALU_GE:  return ($signed(a) >= $signed(b)) ? 1 : 0;
            ALU_EQ:  return (a == b) ? 1 : 0;
            ALU_NE:  return (a != b) ? 1 : 0;
            default: return 0;
        endcase
    endfunction

    function automatic exu_res_t predict(input exu_cmd_t c, input pc_t pc);
        vec_t a;
        vec_t b;
        vec_t y;
        xword_t tgt;
        logic taken;
        exu_res_t e;
        a = ref_regs[c.rs1];
        b = (c.op2_sel == OP2_IMM) ? {4{c.imm}} : ref_regs[c.rs2];
        for (int l = 0; l < 4; l++) begin
            y[l*32 +: 32] = lane_op(c.alu_cmd, a[l*32 +: 32], b[l*32 +: 32]);
        end
        tgt = ((c.sum2_sel == SUM2_REG_IMM) ? a[31:0] : pc) + c.imm;
        if (c.jump) tgt[0] = 1'b0;
        taken = c.jump | (c.branch & (y[31:0] != 0));
        e    = '0;
        e.pc = pc;
        e.rd = c.rd;
        if (c.illegal) begin
            e = '{pc: pc, rd: c.rd, wb_en: 0, wb_data: 0, redirect: 1,
                  target: `EXU_TRAP_VECTOR, exc_code: EXC_ILLEGAL_INSTR, trap_val: c.imm};
        end else if (taken && tgt[1]) begin                 // Misaligned target
            e = '{pc: pc, rd: c.rd, wb_en: 0, wb_data: 0, redirect: 1,
                  target: `EXU_TRAP_VECTOR, exc_code: EXC_INSTR_MISALIGN, trap_val: tgt};
        end else begin
            e.redirect = taken;
            e.target   = tgt;
            e.wb_en    = (c.wb_sel != WB_NONE) && (c.rd != 0);
            case (c.wb_sel)
                WB_ALU:    e.wb_data = y;
                WB_SUM2:   e.wb_data = {4{tgt}};
                WB_IMM:    e.wb_data = {4{c.imm}};
                WB_INC_PC: e.wb_data = {4{pc + 32'd4}};
                default:   e.wb_data = '0;
            endcase
        end
        return e;
    endfunction

    // ----------------------------
    // Program
    // ----------------------------
    task automatic load_program();
        exu_cmd_t c;
        for (int i = 0; i < 256; i++) begin
            c         = make_cmd(0, 0, 0, i * 4, ALU_NONE, OP2_REG, WB_NONE);
            c.illegal = 1'b1;                               // Fill traps with its own address
            rom[i]    = c;
        end
        rom['h200 >> 2] = make_cmd(1, 0, 0, 5, ALU_ADD, OP2_IMM, WB_ALU);
        rom['h204 >> 2] = make_cmd(2, 1, 0, 7, ALU_ADD, OP2_IMM, WB_ALU);      // Bypass
        rom['h208 >> 2] = make_cmd(3, 1, 2, 0, ALU_SUB, OP2_REG, WB_ALU);
        rom['h20c >> 2] = make_cmd(0, 2, 0, 1, ALU_ADD, OP2_IMM, WB_ALU);      // To x0
        rom['h210 >> 2] = make_cmd(4, 3, 1, 0, ALU_SLT, OP2_REG, WB_ALU);
        rom['h214 >> 2] = make_cmd(5, 0, 0, 32'h1234_5678, ALU_NONE, OP2_REG, WB_IMM);
        c = make_cmd(0, 1, 1, 12, ALU_EQ, OP2_REG, WB_NONE);
        c.branch = 1'b1;
        rom['h218 >> 2] = c;                                // Taken to 0x224
        rom['h21c >> 2] = make_cmd(6, 0, 0, 99, ALU_ADD, OP2_IMM, WB_ALU);
        c = make_cmd(0, 1, 1, 8, ALU_NE, OP2_REG, WB_NONE);
        c.branch = 1'b1;
        rom['h224 >> 2] = c;                                // Not taken
        c = make_cmd(7, 0, 0, 8, ALU_NONE, OP2_REG, WB_INC_PC);
        c.jump = 1'b1;
        rom['h228 >> 2] = c;                                // Link jump to 0x230
        rom['h230 >> 2] = make_cmd(8, 7, 5, 0, ALU_XOR, OP2_REG, WB_ALU);
        c = make_cmd(9, 1, 0, 32'h2fb, ALU_NONE, OP2_REG, WB_INC_PC);
        c.jump     = 1'b1;
        c.sum2_sel = SUM2_REG_IMM;
        rom['h234 >> 2] = c;                                // Register jump to 0x300
        rom['h300 >> 2] = make_cmd(10, 9, 4, 0, ALU_OR, OP2_REG, WB_ALU);
        c = make_cmd(11, 0, 0, 6, ALU_NONE, OP2_REG, WB_INC_PC);
        c.jump = 1'b1;
        rom['h304 >> 2] = c;                                // Misaligned target
        rom['h100 >> 2] = make_cmd(12, 12, 0, 1, ALU_ADD, OP2_IMM, WB_ALU);
        rom['h104 >> 2] = make_cmd(13, 12, 10, 0, ALU_AND, OP2_REG, WB_ALU);
        rom['h108 >> 2] = make_cmd(15, 13, 12, 0, ALU_GE, OP2_REG, WB_ALU);
        c = make_cmd(14, 0, 0, 32'hdead_beef, ALU_NONE, OP2_REG, WB_IMM);
        c.illegal = 1'b1;
        rom['h10c >> 2] = c;                                // Back to trap vector
    endtask

    // ----------------------------
    // Stimulus and fetch
    // ----------------------------
    initial begin
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        retire_ready = 1'b0;
        fetch_pc     = `EXU_RST_VECTOR;
        ref_pc       = `EXU_RST_VECTOR;
        for (int i = 0; i < 16; i++) ref_regs[i] = '0;
        load_program();
        repeat (5) @(negedge clk);
        rst_n     = 1'b1;
        cmd_valid = 1'b1;
        n_wait    = 0;
        forever begin                                       // Wait for reset exit
            @(posedge clk);
            if (new_pc_req) break;
            compare_bit("cmd_ready before reset exit", cmd_ready, 1'b0);
            n_wait++;
            if (n_wait > 20) fail_now("Reset-exit redirect never arrived");
        end
        if (n_wait != `EXU_INIT_DELAY) mismatch("reset-exit delay", n_wait, `EXU_INIT_DELAY);
        compare_pc("reset-exit new_pc", new_pc, `EXU_RST_VECTOR);
    end

    always @(negedge clk) begin
        logic rdy_a;
        logic rdy_b;
        cmd          = rom[fetch_pc[9:2]];
        rdy_a        = lfsr[0];
        lfsr         = lfsr_step(lfsr);
        rdy_b        = lfsr[0];
        lfsr         = lfsr_step(lfsr);
        retire_ready = rdy_a | rdy_b;                       // Mostly ready
    end

    always @(posedge clk) begin
        if (new_pc_req) fetch_pc = new_pc;
        else if (cmd_valid && cmd_ready) fetch_pc = fetch_pc + 32'd4;
    end

    // ----------------------------
    // Retire compare
    // ----------------------------
    always @(posedge clk) begin
        exu_res_t e;
        if (rst_n && retire_valid && retire_ready) begin
            e = predict(rom[ref_pc[9:2]], ref_pc);
            compare_pc("retire_pc", retire_pc, e.pc);
            compare_exc("retire_exc_code", retire_exc_code, e.exc_code);
            if (e.exc_code != EXC_NONE) begin
                compare_pc("retire_trap_val", retire_trap_val, e.trap_val);
            end
            compare_bit("wb_en", wb_en, e.wb_en);
            if (e.wb_en) begin
                compare_reg("wb_addr", wb_addr, e.rd);
                compare_vec("wb_data", wb_data, e.wb_data);
                ref_regs[e.rd] = e.wb_data;
            end
            compare_bit("new_pc_req", new_pc_req, e.redirect);
            if (e.redirect) compare_pc("new_pc", new_pc, e.target);
            ref_pc = e.redirect ? e.target : ref_pc + 32'd4;
            n_ret++;
            if (n_ret == N_REC) begin
                $display("TEST RESULT: PASS");
                $finish;
            end
        end else if (rst_n) begin
            compare_bit("wb_en without retire", wb_en, 1'b0);
        end
    end

    initial begin
        #(PERIOD * (N_REC * 40 + 20));                      // 40 cycles per record
        fail_now("Timeout: retire records stopped arriving");
    end

endmodule

`default_nettype wire

// File: bench/exu_assert.sv
// ----------------------------
// EXU handshake checks
// Bound to execute and commit stages
// ----------------------------
`timescale 1ns/10ps
`default_nettype none

module exu_assert import exu_pkg::*; #(
    parameter int W = 1
) (
    input logic         clk,
    input logic         rst_n,
    input logic         valid,
    input logic         ready,
    input logic [W-1:0] payload,
    input logic         wb_en,
    input exc_code_e    exc_code,
    input logic         new_pc_req,
    input logic         flush_valid     // Entry a redirect must clear
);

    // Held item stays put unless flushed
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        valid && !ready && !new_pc_req |=> valid && $stable(payload))
        else $error("payload changed while stalled");

    no_wb_on_exc: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_en && exc_code != EXC_NONE))
        else $error("write enabled with exception");

    flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        new_pc_req |=> !flush_valid)
        else $error("entry not flushed after redirect");

endmodule

bind exu_execute exu_assert #(.W($bits(exu_pkg::exu_cmd_t) + 32)) exec_chk (
    .clk(clk), .rst_n(rst_n), .valid(q.valid), .ready(q.ready),
    .payload({q.cmd, q.pc}), .wb_en(r_valid & r_res.wb_en),
    .exc_code(r_res.exc_code), .new_pc_req(new_pc_req), .flush_valid(q.valid)
);

bind exu_commit exu_assert #(.W($bits(exu_pkg::exu_res_t))) commit_chk (
    .clk(clk), .rst_n(rst_n), .valid(r.valid), .ready(r.ready),
    .payload(r.res), .wb_en(wb_en), .exc_code(r.res.exc_code),
    .new_pc_req(new_pc_req), .flush_valid(r.valid)
);

`default_nettype wire

// File: hw/exu_top.sv
// ----------------------------
// Vector execution unit top
// Queue, execute and commit stages around the register file
// ----------------------------
`timescale 1ns/10ps
`default_nettype none

module exu_top import exu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // Decoder side
    input  logic        cmd_valid,
    output logic        cmd_ready,
    input  exu_cmd_t    cmd,
    // Retire port
    output logic        retire_valid,
    input  logic        retire_ready,
    output pc_t         retire_pc,
    output exc_code_e   retire_exc_code,
    output xword_t      retire_trap_val,
    output logic        wb_en,
    output reg_addr_t   wb_addr,
    output vec_t        wb_data,
    // Fetch redirect
    output logic        new_pc_req,
    output pc_t         new_pc
);

    exu_cmd_if cmd_q ();            // Queue -> execute
    exu_res_if exe_res ();          // Execute -> commit

    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    vec_t       rs1_data;
    vec_t       rs2_data;

    exu_queue queue_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd        (cmd),
        .new_pc_req (new_pc_req),
        .new_pc     (new_pc),
        .q          (cmd_q.src)
    );

    exu_execute execute_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .q          (cmd_q.dst),
        .r          (exe_res.src),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .wb_en      (wb_en),            // Bypass source
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .new_pc_req (new_pc_req)
    );

    exu_commit commit_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .r               (exe_res.dst),
        .retire_valid    (retire_valid),
        .retire_ready    (retire_ready),
        .retire_pc       (retire_pc),
        .retire_exc_code (retire_exc_code),
        .retire_trap_val (retire_trap_val),
        .wb_en           (wb_en),
        .wb_addr         (wb_addr),
        .wb_data         (wb_data),
        .new_pc_req      (new_pc_req),
        .new_pc          (new_pc)
    );

    exu_regfile regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

// File: hw/exu/exu_commit.sv
// ----------------------------
// EXU commit stage
// Retire record, register write, redirect and reset exit
// ----------------------------
`timescale 1ns/10ps
`default_nettype none
`include "exu_cfg.svh"

module exu_commit import exu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    exu_res_if.dst      r,
    output logic        retire_valid,
    input  logic        retire_ready,
    output pc_t         retire_pc,
    output exc_code_e   retire_exc_code,
    output xword_t      retire_trap_val,
    output logic        wb_en,
    output reg_addr_t   wb_addr,
    output vec_t        wb_data,
    output logic        new_pc_req,
    output pc_t         new_pc
);

    logic [`EXU_INIT_DELAY:0]   init_v;     // Fills with ones after reset
    logic                       init_pulse;
    logic                       retire;

    assign r.ready = retire_ready;
    assign retire  = r.valid & retire_ready;

    // Retire record straight from the held result
    assign retire_valid    = r.valid;
    assign retire_pc       = r.res.pc;
    assign retire_exc_code = r.res.exc_code;
    assign retire_trap_val = r.res.trap_val;

    // Write only on handshake, never on trap or to register 0
    assign wb_en   = retire & r.res.wb_en & (r.res.exc_code == EXC_NONE) & (r.res.rd != '0);
    assign wb_addr = r.res.rd;
    assign wb_data = r.res.wb_data;

    // ----------------------------
    // Reset exit and redirect
    // ----------------------------
    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            init_v <= '0;
        end else if (~&init_v) begin
            init_v <= {init_v[`EXU_INIT_DELAY-1:0], 1'b1};
        end
    end

    assign init_pulse = init_v[`EXU_INIT_DELAY-1] & ~init_v[`EXU_INIT_DELAY];  // One cycle

    // Pipeline is empty at reset exit, so the two sources never overlap
    assign new_pc_req = init_pulse | (retire & r.res.redirect);
    assign new_pc     = init_pulse ? `EXU_RST_VECTOR : r.res.target;

endmodule

`default_nettype wire

// File: hw/exu/exu_execute.sv
// ----------------------------
// EXU execute stage
// Operand fetch with bypass, lane ALU, SUM2 and branch decision
// Result register feeds the commit stage
// ----------------------------
`timescale 1ns/10ps
`default_nettype none
`include "exu_cfg.svh"

module exu_execute import exu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    exu_cmd_if.dst      q,
    exu_res_if.src      r,
    output reg_addr_t   rs1_addr,
    output reg_addr_t   rs2_addr,
    input  vec_t        rs1_data,
    input  vec_t        rs2_data,
    input  logic        wb_en,
    input  reg_addr_t   wb_addr,
    input  vec_t        wb_data,
    input  logic        new_pc_req
);

    vec_t       rs1_v;
    vec_t       rs2_v;
    vec_t       imm_v;
    vec_t       op2;
    vec_t       alu_res;
    xword_t     imm_w;
    xword_t     sum2_op1;
    xword_t     sum2_raw;
    xword_t     sum2;
    pc_t        inc_pc;
    logic       taken;
    logic       misalign;
    logic       exc;
    logic       capture;
    logic       r_valid;
    exu_res_t   res_d;
    exu_res_t   r_res;

    // ----------------------------
    // Operand fetch
    // ----------------------------
    assign rs1_addr = q.cmd.rs1;
    assign rs2_addr = q.cmd.rs2;

    // Retiring write lands on the same edge, take it early
    assign rs1_v = (wb_en && wb_addr == rs1_addr && rs1_addr != '0) ? wb_data : rs1_data;
    assign rs2_v = (wb_en && wb_addr == rs2_addr && rs2_addr != '0) ? wb_data : rs2_data;

    assign imm_w = xword_t'(q.cmd.imm);
    assign imm_v = {`EXU_LANES{imm_w}};                         // Broadcast
    assign op2   = (q.cmd.op2_sel == OP2_IMM) ? imm_v : rs2_v;

    exu_lane_alu lane_alu_i (
        .cmd (q.cmd.alu_cmd),
        .op1 (rs1_v),
        .op2 (op2),
        .res (alu_res)
    );

    // ----------------------------
    // SUM2 and control flow
    // ----------------------------
    assign sum2_op1 = (q.cmd.sum2_sel == SUM2_REG_IMM) ? rs1_v[`EXU_XLEN-1:0] : q.pc;
    assign sum2_raw = sum2_op1 + imm_w;
    assign sum2     = q.cmd.jump ? {sum2_raw[`EXU_XLEN-1:1], 1'b0} : sum2_raw;
    assign inc_pc   = q.pc + pc_t'(4);

    assign taken    = q.cmd.jump | (q.cmd.branch & alu_res[0]);     // Lane 0 compare
    assign misalign = taken & sum2[1];
    assign exc      = q.cmd.illegal | misalign;

    always_comb begin
        res_d          = '0;
        res_d.pc       = q.pc;
        res_d.rd       = q.cmd.rd;
        res_d.wb_en    = (q.cmd.wb_sel != WB_NONE) & ~exc;      // No write on trap
        case (q.cmd.wb_sel)
            WB_ALU:    res_d.wb_data = alu_res;
            WB_SUM2:   res_d.wb_data = {`EXU_LANES{sum2}};
            WB_IMM:    res_d.wb_data = imm_v;
            WB_INC_PC: res_d.wb_data = {`EXU_LANES{inc_pc}};
            default:   res_d.wb_data = '0;
        endcase
        res_d.redirect = taken | exc;
        res_d.target   = exc ? `EXU_TRAP_VECTOR : sum2;
        res_d.exc_code = EXC_NONE;
        if (q.cmd.illegal) begin                                // Decoder fault first
            res_d.exc_code = EXC_ILLEGAL_INSTR;
            res_d.trap_val = imm_w;
        end else if (misalign) begin
            res_d.exc_code = EXC_INSTR_MISALIGN;
            res_d.trap_val = sum2;
        end
    end

    // ----------------------------
    // Result register
    // ----------------------------
    assign q.ready = ~r_valid | r.ready;
    assign capture = q.valid & q.ready & ~new_pc_req;           // Flushed on redirect

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            r_valid <= 1'b0;
        end else if (capture) begin
            r_valid <= 1'b1;
        end else if (r.ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            r_res <= res_d;
        end
    end

    assign r.valid = r_valid;
    assign r.res   = r_res;

endmodule

`default_nettype wire

// File: hw/exu/exu_queue.sv
// ----------------------------
// EXU input queue
// One-entry command register with sequential PC
// ----------------------------
`timescale 1ns/10ps
`default_nettype none
`include "exu_cfg.svh"

module exu_queue import exu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    input  exu_cmd_t    cmd,
    input  logic        new_pc_req,
    input  pc_t         new_pc,
    exu_cmd_if.src      q
);

    logic       started;        // Set by reset-exit redirect
    logic       q_valid;
    exu_cmd_t   q_cmd;
    pc_t        q_pc;
    pc_t        seq_pc;         // PC for next accepted command
    logic       accept;

    // Blocked before reset exit and in any redirect cycle
    assign cmd_ready = started & ~new_pc_req & (~q_valid | q.ready);
    assign accept    = cmd_valid & cmd_ready;

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            started <= 1'b0;
            q_valid <= 1'b0;
            seq_pc  <= `EXU_RST_VECTOR;
        end else begin
            if (new_pc_req) begin
                started <= 1'b1;
                q_valid <= 1'b0;            // Flush
                seq_pc  <= new_pc;
            end else if (accept) begin
                q_valid <= 1'b1;
                seq_pc  <= seq_pc + pc_t'(4);
            end else if (q.ready) begin
                q_valid <= 1'b0;            // Moved to execute
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            q_cmd <= cmd;
            q_pc  <= seq_pc;
        end
    end

    assign q.valid = q_valid;
    assign q.cmd   = q_cmd;
    assign q.pc    = q_pc;

endmodule

`default_nettype wire

// File: hw/exu/exu_regfile.sv
// ----------------------------
// Lane-vector register file
// Two combinational reads, one write, register 0 is zero
// ----------------------------
`timescale 1ns/10ps
`default_nettype none
`include "exu_cfg.svh"

module exu_regfile import exu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  reg_addr_t   rs1_addr,
    input  reg_addr_t   rs2_addr,
    output vec_t        rs1_data,
    output vec_t        rs2_data,
    input  logic        wb_en,
    input  reg_addr_t   wb_addr,
    input  vec_t        wb_data
);

    localparam int NREGS = 1 << `EXU_REG_AW;

    vec_t regs [NREGS];

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;       // Register 0 never written
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: hw/exu/exu_lane_alu.sv
// ----------------------------
// Lane ALU
// One integer operator per lane, shared command
// ----------------------------
`timescale 1ns/10ps
`default_nettype none
`include "exu_cfg.svh"

module exu_lane_alu import exu_pkg::*; (
    input  alu_cmd_e    cmd,
    input  vec_t        op1,
    input  vec_t        op2,
    output vec_t        res
);

    for (genvar i = 0; i < `EXU_LANES; i++) begin : g_lane
        xword_t a;
        xword_t b;
        xword_t y;
        logic   lt;

        assign a  = op1[i*`EXU_XLEN +: `EXU_XLEN];
        assign b  = op2[i*`EXU_XLEN +: `EXU_XLEN];
        assign lt = $signed(a) < $signed(b);                    // Signed compare

        always_comb begin
            case (cmd)
                ALU_ADD: y = a + b;
                ALU_SUB: y = a - b;
                ALU_AND: y = a & b;
                ALU_OR:  y = a | b;
                ALU_XOR: y = a ^ b;
                ALU_SLT,
                ALU_LT:  y = xword_t'(lt);
                ALU_EQ:  y = xword_t'(a == b);
                ALU_NE:  y = xword_t'(a != b);
                ALU_GE:  y = xword_t'(!lt);                     // 1 or 0
                default: y = '0;                                // ALU_NONE
            endcase
        end

        assign res[i*`EXU_XLEN +: `EXU_XLEN] = y;
    end

endmodule

`default_nettype wire

// File: common/exu_res_if.sv
// ----------------------------
// Execute to commit result link
// ----------------------------
`timescale 1ns/10ps
`default_nettype none

interface exu_res_if import exu_pkg::*; ();

    logic       valid;
    logic       ready;          // Retire side accepts
    exu_res_t   res;

    modport src (
        output valid,
        output res,
        input  ready
    );

    modport dst (
        input  valid,
        input  res,
        output ready
    );

endinterface

`default_nettype wire

// File: common/exu_cmd_if.sv
// ----------------------------
// Queue to execute command link
// ----------------------------
`timescale 1ns/10ps
`default_nettype none

interface exu_cmd_if import exu_pkg::*; ();

    logic       valid;
    logic       ready;
    exu_cmd_t   cmd;            // Held stable while valid
    pc_t        pc;             // PC assigned by the queue

    modport src (
        output valid, cmd, pc,
        input  ready
    );

    modport dst (
        input  valid, cmd, pc,
        output ready
    );

endinterface

`default_nettype wire

// File: common/exu_pkg.sv
// ----------------------------
// EXU shared types
// Lane vectors, decode enums, command and result records
// ----------------------------
`default_nettype none
`include "exu_cfg.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0]            xword_t;       // One lane
    typedef logic [`EXU_LANES*`EXU_XLEN-1:0] vec_t;         // Lane 0 in low bits
    typedef logic [`EXU_REG_AW-1:0]          reg_addr_t;
    typedef logic [`EXU_XLEN-1:0]            pc_t;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_EQ, ALU_NE, ALU_LT, ALU_GE              // Compares give 1 or 0
    } alu_cmd_e;

    typedef enum logic {OP2_REG, OP2_IMM} op2_sel_e;
    typedef enum logic {SUM2_PC_IMM, SUM2_REG_IMM} sum2_sel_e;

    typedef enum logic [2:0] {
        WB_NONE, WB_ALU, WB_SUM2, WB_IMM, WB_INC_PC
    } wb_sel_e;

    typedef enum logic [3:0] {
        EXC_NONE, EXC_INSTR_MISALIGN, EXC_ILLEGAL_INSTR
    } exc_code_e;

    // Decoded command from the decoder
    typedef struct packed {
        reg_addr_t              rs1;
        reg_addr_t              rs2;
        reg_addr_t              rd;
        logic [`EXU_IMM_W-1:0]  imm;
        alu_cmd_e               alu_cmd;
        op2_sel_e               op2_sel;
        sum2_sel_e              sum2_sel;
        wb_sel_e                wb_sel;
        logic                   jump;
        logic                   branch;
        logic                   illegal;        // Flagged by decoder
    } exu_cmd_t;

    // Executed result waiting for retire
    typedef struct packed {
        pc_t        pc;
        reg_addr_t  rd;
        logic       wb_en;      // Cleared on exception
        vec_t       wb_data;
        logic       redirect;   // Taken jump/branch or trap
        pc_t        target;
        exc_code_e  exc_code;
        xword_t     trap_val;
    } exu_res_t;

endpackage

`default_nettype wire

// File: common/exu_cfg.svh
// ----------------------------
// EXU configuration constants
// Datapath widths, lane count and fixed PC vectors
// ----------------------------
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

`define EXU_XLEN        32          // Lane width
`define EXU_LANES       4           // Lanes per register
`define EXU_REG_AW      4           // 16 registers
`define EXU_IMM_W       32          // Decoded immediate

// PC vectors
`define EXU_RST_VECTOR  32'h200     // Target of reset-exit redirect
`define EXU_TRAP_VECTOR 32'h100     // Exception entry

// Cycles from reset release to the reset-exit redirect
`define EXU_INIT_DELAY  3

`endif
